// File: include/ooo_defines.svh
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// data path and pc width
`define XLEN 32

// architectural destination register number
`define REG_W 5

// reorder buffer geometry
`define ROB_DEPTH 16
`define ROB_TAG_W 4

// multiplier pipeline stages
`define MUL_LAT 3

`endif

// File: design/ooo_pkg.sv
`include "ooo_defines.svh"

package ooo_pkg;

    // every 3-bit code is a legal opcode
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLT = 3'd5,
        OP_MUL = 3'd6,
        OP_BEQ = 3'd7
    } op_e;

    // life of one buffer entry
    typedef enum logic [1:0] {
        ENT_FREE   = 2'd0,
        ENT_ISSUED = 2'd1,
        ENT_DONE   = 2'd2
    } entry_state_e;

    // names a buffer entry
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

endpackage

// File: design/ooo_ifs.sv
`include "ooo_defines.svh"

// decode register to execute, one strobe per instruction
interface issue_if import ooo_pkg::*; ();
    logic             valid;
    op_e              op;
    rob_tag_t         tag;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] taken_pc;
    logic [`XLEN-1:0] fall_pc;

    modport source (output valid, op, tag, a, b, taken_pc, fall_pc);
    modport sink   (input  valid, op, tag, a, b, taken_pc, fall_pc);
endinterface

// entry allocation, written at the edge where valid is high
interface alloc_if import ooo_pkg::*; ();
    logic              valid;
    op_e               op;
    logic [`REG_W-1:0] rd;
    logic [`XLEN-1:0]  pc;
    logic              pred;
    rob_tag_t          tag;
    logic              full;

    modport decode (output valid, op, rd, pc, pred, input  tag, full);
    modport buffer (input  valid, op, rd, pc, pred, output tag, full);
endinterface

// result writeback, no back-pressure
interface wb_if import ooo_pkg::*; ();
    logic             valid;
    rob_tag_t         tag;
    logic [`XLEN-1:0] data;
    logic             taken;
    logic [`XLEN-1:0] next_pc;

    modport source (output valid, tag, data, taken, next_pc);
    modport sink   (input  valid, tag, data, taken, next_pc);
endinterface

// File: design/issue_decode.sv
`include "ooo_defines.svh"

module issue_decode import ooo_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    output logic              instr_ready,
    input  logic [2:0]        instr_op,
    input  logic [`REG_W-1:0] instr_rd,
    input  logic [`XLEN-1:0]  instr_a,
    input  logic [`XLEN-1:0]  instr_b,
    input  logic [`XLEN-1:0]  instr_imm,
    input  logic [`XLEN-1:0]  instr_pc,
    input  logic              instr_pred,
    input  logic              flush,
    alloc_if.decode           alloc,
    issue_if.source           issue
);

    op_e  dec_op;
    logic accept;

    // raw code maps one to one onto the enum
    assign dec_op = op_e'(instr_op);

    // stall while the buffer is full or a redirect is in progress
    assign instr_ready = !alloc.full && !flush;
    assign accept      = instr_valid && instr_ready;

    // entry is allocated at the accepting edge
    assign alloc.valid = accept;
    assign alloc.op    = dec_op;
    assign alloc.rd    = instr_rd;
    assign alloc.pc    = instr_pc;
    assign alloc.pred  = instr_pred;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= accept;
        end
    end

    // payload follows the allocated tag into execute
    always_ff @(posedge clk) begin
        if (accept) begin
            issue.op  <= dec_op;
            issue.tag <= alloc.tag;
            issue.a   <= instr_a;
            issue.b   <= instr_b;
            // both branch targets ready before execute
            issue.taken_pc <= instr_pc + instr_imm;
            issue.fall_pc  <= instr_pc + `XLEN'd4;
        end
    end

endmodule

// File: design/exec_unit.sv
`include "ooo_defines.svh"

module exec_unit import ooo_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    flush,
    issue_if.sink   issue,
    wb_if.source    alu_wb,
    wb_if.source    mul_wb
);

    logic [`XLEN-1:0] alu_res;
    logic             br_taken;
    logic             is_mul;

    // multiplier stages, index 0 is the first
    logic             mul_valid [`MUL_LAT];
    rob_tag_t         mul_tag   [`MUL_LAT];
    logic [`XLEN-1:0] mul_data  [`MUL_LAT];

    assign is_mul = (issue.op == OP_MUL);

    always_comb begin
        alu_res  = '0;
        br_taken = 1'b0;
        case (issue.op)
            OP_ADD: alu_res = issue.a + issue.b;
            OP_SUB: alu_res = issue.a - issue.b;
            OP_AND: alu_res = issue.a & issue.b;
            OP_OR:  alu_res = issue.a | issue.b;
            OP_XOR: alu_res = issue.a ^ issue.b;
            OP_SLT: alu_res = {{(`XLEN-1){1'b0}}, $signed(issue.a) < $signed(issue.b)};
            OP_BEQ: begin
                br_taken = (issue.a == issue.b);
                // branch reports its outcome as data
                alu_res  = {{(`XLEN-1){1'b0}}, br_taken};
            end
            default: alu_res = '0;
        endcase
    end

    // alu stage
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            alu_wb.valid <= 1'b0;
        end else begin
            alu_wb.valid <= issue.valid && !is_mul;
        end
    end

    always_ff @(posedge clk) begin
        alu_wb.tag     <= issue.tag;
        alu_wb.data    <= alu_res;
        alu_wb.taken   <= br_taken;
        alu_wb.next_pc <= br_taken ? issue.taken_pc : issue.fall_pc;
    end

    // multiplier valid bits
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int i = 0; i < `MUL_LAT; i++) begin
                mul_valid[i] <= 1'b0;
            end
        end else begin
            mul_valid[0] <= issue.valid && is_mul;
            for (int i = 1; i < `MUL_LAT; i++) begin
                mul_valid[i] <= mul_valid[i-1];
            end
        end
    end

    // low half of the product, then carried down the pipe
    always_ff @(posedge clk) begin
        mul_tag[0]  <= issue.tag;
        mul_data[0] <= issue.a * issue.b;
        for (int i = 1; i < `MUL_LAT; i++) begin
            mul_tag[i]  <= mul_tag[i-1];
            mul_data[i] <= mul_data[i-1];
        end
    end

    assign mul_wb.valid   = mul_valid[`MUL_LAT-1];
    assign mul_wb.tag     = mul_tag[`MUL_LAT-1];
    assign mul_wb.data    = mul_data[`MUL_LAT-1];
    assign mul_wb.taken   = 1'b0;
    assign mul_wb.next_pc = '0;

    // buffer relies on the two ports never naming the same entry
    a_wb_tags_differ: assert property (@(posedge clk) disable iff (!rst_n)
        alu_wb.valid && mul_wb.valid |-> alu_wb.tag != mul_wb.tag);

endmodule

// File: design/reorder_buffer.sv
`include "ooo_defines.svh"

module reorder_buffer import ooo_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    alloc_if.buffer           alloc,
    wb_if.sink                alu_wb,
    wb_if.sink                mul_wb,
    output logic              flush,
    output logic              commit_valid,
    output logic [`REG_W-1:0] commit_rd,
    output logic [`XLEN-1:0]  commit_data,
    output logic [`XLEN-1:0]  commit_pc,
    output logic              redirect_valid,
    output logic [`XLEN-1:0]  redirect_pc
);

    entry_state_e      state   [`ROB_DEPTH];
    op_e               ent_op  [`ROB_DEPTH];
    logic [`REG_W-1:0] ent_rd  [`ROB_DEPTH];
    logic [`XLEN-1:0]  ent_pc  [`ROB_DEPTH];
    logic              ent_pred[`ROB_DEPTH];
    logic [`XLEN-1:0]  ent_data[`ROB_DEPTH];
    logic              ent_taken[`ROB_DEPTH];
    logic [`XLEN-1:0]  ent_next[`ROB_DEPTH];

    rob_tag_t            head;
    rob_tag_t            tail;
    logic [`ROB_TAG_W:0] count;

    logic commit_fire;
    logic head_mispredict;

    assign alloc.tag  = tail;
    assign alloc.full = (count == `ROB_DEPTH);

    assign commit_fire     = (state[head] == ENT_DONE);
    assign head_mispredict = (ent_op[head] == OP_BEQ) &&
                             (ent_taken[head] != ent_pred[head]);

    // control state is wiped on reset and in the flush cycle
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state[i] <= ENT_FREE;
            end
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            commit_valid   <= 1'b0;
            redirect_valid <= 1'b0;
            flush          <= 1'b0;
        end else begin
            if (alloc.valid) begin
                state[tail] <= ENT_ISSUED;
                tail        <= tail + 1'b1;
            end
            if (alu_wb.valid) begin
                state[alu_wb.tag] <= ENT_DONE;
            end
            if (mul_wb.valid) begin
                state[mul_wb.tag] <= ENT_DONE;
            end
            if (commit_fire) begin
                state[head] <= ENT_FREE;
                head        <= head + 1'b1;
            end
            count <= count + (`ROB_TAG_W+1)'(alloc.valid) - (`ROB_TAG_W+1)'(commit_fire);

            commit_valid   <= commit_fire;
            // wrong-path branch still commits, then everything younger goes
            redirect_valid <= commit_fire && head_mispredict;
            flush          <= commit_fire && head_mispredict;
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            ent_op[tail]   <= alloc.op;
            ent_rd[tail]   <= alloc.rd;
            ent_pc[tail]   <= alloc.pc;
            ent_pred[tail] <= alloc.pred;
        end
        if (alu_wb.valid) begin
            ent_data[alu_wb.tag]  <= alu_wb.data;
            ent_taken[alu_wb.tag] <= alu_wb.taken;
            ent_next[alu_wb.tag]  <= alu_wb.next_pc;
        end
        if (mul_wb.valid) begin
            ent_data[mul_wb.tag]  <= mul_wb.data;
            ent_taken[mul_wb.tag] <= mul_wb.taken;
            ent_next[mul_wb.tag]  <= mul_wb.next_pc;
        end
    end

    // commit port payload
    always_ff @(posedge clk) begin
        if (commit_fire) begin
            commit_rd   <= (ent_op[head] == OP_BEQ) ? '0 : ent_rd[head];
            commit_data <= ent_data[head];
            commit_pc   <= ent_pc[head];
            redirect_pc <= ent_next[head];
        end
    end

    a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
        alloc.valid |-> !alloc.full);

    // results in the flush cycle are dropped, so only check outside it
    a_alu_wb_issued: assert property (@(posedge clk) disable iff (!rst_n || flush)
        alu_wb.valid |-> state[alu_wb.tag] == ENT_ISSUED);

    a_mul_wb_issued: assert property (@(posedge clk) disable iff (!rst_n || flush)
        mul_wb.valid |-> state[mul_wb.tag] == ENT_ISSUED);

    // the redirect cycle is the flush cycle and no result survives it
    a_flush_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |-> flush ##1 !(flush || alu_wb.valid || mul_wb.valid));

endmodule

// File: design/ooo_core_top.sv
`include "ooo_defines.svh"

module ooo_core_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    output logic              instr_ready,
    input  logic [2:0]        instr_op,
    input  logic [`REG_W-1:0] instr_rd,
    input  logic [`XLEN-1:0]  instr_a,
    input  logic [`XLEN-1:0]  instr_b,
    input  logic [`XLEN-1:0]  instr_imm,
    input  logic [`XLEN-1:0]  instr_pc,
    input  logic              instr_pred,
    output logic              commit_valid,
    output logic [`REG_W-1:0] commit_rd,
    output logic [`XLEN-1:0]  commit_data,
    output logic [`XLEN-1:0]  commit_pc,
    output logic              redirect_valid,
    output logic [`XLEN-1:0]  redirect_pc
);

    logic flush;

    alloc_if alloc_bus ();
    issue_if issue_bus ();
    wb_if    alu_wb ();
    wb_if    mul_wb ();

    issue_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr_op    (instr_op),
        .instr_rd    (instr_rd),
        .instr_a     (instr_a),
        .instr_b     (instr_b),
        .instr_imm   (instr_imm),
        .instr_pc    (instr_pc),
        .instr_pred  (instr_pred),
        .flush       (flush),
        .alloc       (alloc_bus.decode),
        .issue       (issue_bus.source)
    );

    exec_unit u_exec (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush  (flush),
        .issue  (issue_bus.sink),
        .alu_wb (alu_wb.source),
        .mul_wb (mul_wb.source)
    );

    reorder_buffer u_rob (
        .clk            (clk),
        .rst_n          (rst_n),
        .alloc          (alloc_bus.buffer),
        .alu_wb         (alu_wb.sink),
        .mul_wb         (mul_wb.sink),
        .flush          (flush),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_pc      (commit_pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

// File: verification/ooo_checker.sv
`include "ooo_defines.svh"

module ooo_checker import ooo_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  logic              instr_ready,
    input  logic [2:0]        instr_op,
    input  logic [`REG_W-1:0] instr_rd,
    input  logic [`XLEN-1:0]  instr_a,
    input  logic [`XLEN-1:0]  instr_b,
    input  logic [`XLEN-1:0]  instr_imm,
    input  logic [`XLEN-1:0]  instr_pc,
    input  logic              instr_pred,
    input  logic              commit_valid,
    input  logic [`REG_W-1:0] commit_rd,
    input  logic [`XLEN-1:0]  commit_data,
    input  logic [`XLEN-1:0]  commit_pc,
    input  logic              redirect_valid,
    input  logic [`XLEN-1:0]  redirect_pc,
    output int                alu_errs,
    output int                mul_errs,
    output int                branch_errs,
    output int                flow_errs,
    output int                commits,
    output int                pending
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [2:0]        op;
        logic [`REG_W-1:0] rd;
        logic [`XLEN-1:0]  a;
        logic [`XLEN-1:0]  b;
        logic [`XLEN-1:0]  imm;
        logic [`XLEN-1:0]  pc;
        logic              pred;
    } instr_t;

    // accepted and not yet committed, oldest first
    instr_t q[$];

    function automatic logic [`XLEN-1:0] expect_data(input instr_t t);
        case (t.op)
            OP_ADD:  return t.a + t.b;
            OP_SUB:  return t.a - t.b;
            OP_AND:  return t.a & t.b;
            OP_OR:   return t.a | t.b;
            OP_XOR:  return t.a ^ t.b;
            OP_SLT:  return ($signed(t.a) < $signed(t.b)) ? 1 : 0;
            OP_MUL:  return t.a * t.b;
            OP_BEQ:  return (t.a == t.b) ? 1 : 0;
            default: return '0;
        endcase
    endfunction

    function automatic int mismatch(input string test, input string field,
                                    input logic [`XLEN-1:0] exp,
                                    input logic [`XLEN-1:0] act);
        if (exp === act) begin
            return 0;
        end
        $display("Error %s: %s expected %h actual %h", test, field, exp, act);
        return 1;
    endfunction

    task automatic check_commit();
        instr_t           t;
        string            test;
        logic             taken;
        logic             mispredict;
        logic [`XLEN-1:0] next_pc;
        int               n;
        t          = q.pop_front();
        taken      = (t.a == t.b);
        mispredict = (t.op == OP_BEQ) && (taken != t.pred);
        next_pc    = taken ? t.pc + t.imm : t.pc + 4;
        if (t.op == OP_MUL) begin
            test = "mul_result";
        end else if (t.op != OP_BEQ) begin
            test = "alu_result";
        end else if (!mispredict) begin
            test = "branch";
        end else begin
            test = "mispredict";
        end
        // pc names the instruction, so order slips show up here
        n = mismatch(test, "commit_pc", t.pc, commit_pc);
        n += mismatch(test, "commit_rd", (t.op == OP_BEQ) ? 0 : t.rd, commit_rd);
        n += mismatch(test, "commit_data", expect_data(t), commit_data);
        n += mismatch(test, "redirect_valid", mispredict, redirect_valid);
        if (mispredict && redirect_valid) begin
            n += mismatch(test, "redirect_pc", next_pc, redirect_pc);
        end
        if (t.op == OP_MUL) begin
            mul_errs += n;
        end else if (t.op == OP_BEQ) begin
            branch_errs += n;
        end else begin
            alu_errs += n;
        end
    endtask

    initial begin
        alu_errs    = 0;
        mul_errs    = 0;
        branch_errs = 0;
        flow_errs   = 0;
        commits     = 0;
        pending     = 0;
    end

    // mid-cycle sampling, commit side first, then the edge to come
    always @(negedge clk) begin
        if (rst_n) begin
            if (redirect_valid && !commit_valid) begin
                $display("redirect raised at pc %h without a commit", redirect_pc);
                flow_errs++;
            end
            if (redirect_valid && instr_ready) begin
                $display("Error backpressure: instr_ready expected 0 actual 1");
                flow_errs++;
            end
            if (commit_valid) begin
                commits++;
                if (q.size() == 0) begin
                    $display("commit at pc %h with no outstanding instruction", commit_pc);
                    flow_errs++;
                end else begin
                    check_commit();
                end
            end
            // younger instructions die with the branch
            if (redirect_valid) begin
                q.delete();
            end
            if (instr_valid && instr_ready) begin
                q.push_back({instr_op, instr_rd, instr_a, instr_b, instr_imm, instr_pc,
                             instr_pred});
            end
            pending = q.size();
        end
    end

endmodule

// File: verification/ooo_tb.sv
`include "ooo_defines.svh"

module ooo_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * (`MUL_LAT + 10);

    logic              clk;
    logic              rst_n;
    logic              instr_valid;
    logic              instr_ready;
    logic [2:0]        instr_op;
    logic [`REG_W-1:0] instr_rd;
    logic [`XLEN-1:0]  instr_a;
    logic [`XLEN-1:0]  instr_b;
    logic [`XLEN-1:0]  instr_imm;
    logic [`XLEN-1:0]  instr_pc;
    logic              instr_pred;
    logic              commit_valid;
    logic [`REG_W-1:0] commit_rd;
    logic [`XLEN-1:0]  commit_data;
    logic [`XLEN-1:0]  commit_pc;
    logic              redirect_valid;
    logic [`XLEN-1:0]  redirect_pc;

    int          alu_errs;
    int          mul_errs;
    int          branch_errs;
    int          flow_errs;
    int          commits;
    int          pending;
    logic [31:0] lfsr;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ooo_core_top dut0 (.*);

    ooo_checker chk0 (.*);

    // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    task automatic draw(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
    endtask

    // operands in -2..1 so equal pairs are common
    task automatic present_next(input int idx);
        logic [31:0] r;
        draw(3, r);
        instr_op <= r[2:0];
        draw(`REG_W, r);
        instr_rd <= r[`REG_W-1:0];
        draw(2, r);
        instr_a <= {{(`XLEN-2){r[1]}}, r[1:0]};
        draw(2, r);
        instr_b <= {{(`XLEN-2){r[1]}}, r[1:0]};
        draw(6, r);
        instr_imm <= {r[5:0], 2'b00};
        draw(1, r);
        instr_pred <= r[0];
        instr_pc   <= 32'h1000 + 4 * idx;
    endtask

    initial begin
        int          accepted;
        int          presented;
        logic        busy;
        logic [31:0] r;
        accepted  = 0;
        presented = 0;
        busy      = 1'b0;
        lfsr      = 32'h6b65f531;
        rst_n       <= 1'b0;
        instr_valid <= 1'b0;
        instr_op    <= '0;
        instr_rd    <= '0;
        instr_a     <= '0;
        instr_b     <= '0;
        instr_imm   <= '0;
        instr_pc    <= '0;
        instr_pred  <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        while (accepted < NUM_INSTR) begin
            @(posedge clk);
            // held until the handshake completes
            if (busy && instr_ready) begin
                accepted++;
                busy = 1'b0;
            end
            if (!busy) begin
                draw(2, r);
                if (presented < NUM_INSTR && r[1:0] != 2'b00) begin
                    present_next(presented);
                    presented++;
                    busy = 1'b1;
                end
                instr_valid <= busy;
            end
        end
        while (pending != 0) begin
            @(posedge clk);
        end
        // catch any stray commit after the drain
        repeat (20) @(posedge clk);
        if (commits == 0) begin
            $display("no instruction committed during the run");
        end
        $display("errors alu %0d mul %0d branch %0d flow %0d, commits %0d",
                 alu_errs, mul_errs, branch_errs, flow_errs, commits);
        if (alu_errs + mul_errs + branch_errs + flow_errs == 0 && commits > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles with %0d instructions outstanding",
                 TIMEOUT_CYCLES, pending);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
design/ooo_pkg.sv
design/ooo_ifs.sv
design/issue_decode.sv
design/exec_unit.sv
design/reorder_buffer.sv
design/ooo_core_top.sv
verification/ooo_checker.sv
verification/ooo_tb.sv

// File: Bender.yml
package:
  name: ooo_slice

sources:
  - include_dirs:
      - include
    files:
      - design/ooo_pkg.sv
      - design/ooo_ifs.sv
      - design/issue_decode.sv
      - design/exec_unit.sv
      - design/reorder_buffer.sv
      - design/ooo_core_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/ooo_checker.sv
      - verification/ooo_tb.sv
